// File: ntm_rank_top.f
ntm_rank_pkg.sv
ntm_rank_regs.sv
ntm_matrix_buffer.sv
ntm_scalar_adder.sv
ntm_scalar_multiplier.sv
ntm_matrix_rank.sv
ntm_rank_top.sv
ntm_rank_chk.sv
ntm_rank_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ntm_rank_tb \
  -f ntm_rank_top.f -o ntm_rank_sim \
  && ./obj_dir/ntm_rank_sim | tee /dev/stderr | grep -F "TESTBENCH PASSED" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: ntm_rank_tb.sv
// Random and directed matrices over APB against a modular Gaussian model. Stops at the first error or at the timeout.
`default_nettype none

module ntm_rank_tb;

  import ntm_rank_pkg::*;

  ////////////////////////////////////////////////////////////
  // Run length and timeout budget
  ////////////////////////////////////////////////////////////

  localparam int RESET_CYCLES = 16;
  // 40 random runs plus the directed ones
  localparam int NUM_RUNS = 45;
  localparam int MAX_UPDATES = 16;
  // Two multiplies, a subtract and the write back
  localparam int UPDATE_CYCLES = 40;
  // Config, element writes and status reads per run
  localparam int APB_CYCLES = 160;
  localparam int TIMEOUT_CYCLES =
    2 * (RESET_CYCLES + NUM_RUNS * (MAX_UPDATES * UPDATE_CYCLES + APB_CYCLES));

  logic CLK;
  logic RST;
  logic psel;
  logic penable;
  logic pwrite;
  paddr_t paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic irq;

  logic [31:0] seed;
  // Row major matrix as written to the DUT
  int unsigned mat [MAT_DIM*MAT_DIM];
  int unsigned primes [3];
  int cycles = 0;
  int irq_count = 0;
  int runs = 0;

  ntm_rank_top ntm_rank_top_inst (
    .CLK     (CLK),
    .RST     (RST),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the runs did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  // Count irq pulses at mid cycle
  always @(negedge CLK) begin
    if (irq) begin
      irq_count <= irq_count + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    seed = xorshift32(seed);
    return seed % n;
  endfunction

  // b^e mod m by square and multiply
  function automatic longint unsigned pow_mod(input longint unsigned b,
                                              input longint unsigned e,
                                              input longint unsigned m);
    longint unsigned r;
    longint unsigned x;
    longint unsigned n;
    r = 1;
    x = b % m;
    n = e;
    while (n != 0) begin
      if ((n & 1) != 0) begin
        r = (r * x) % m;
      end
      x = (x * x) % m;
      n = n >> 1;
    end
    return r;
  endfunction

  // Normalized elimination with a Fermat inverse
  function automatic int unsigned model_rank(input int unsigned p, input int nr, input int nc);
    longint unsigned a [MAT_DIM*MAT_DIM];
    logic [MAT_DIM-1:0] used;
    longint unsigned inv;
    longint unsigned f;
    int pr;
    int unsigned rk;
    for (int i = 0; i < MAT_DIM*MAT_DIM; i++) begin
      a[i] = mat[i];
    end
    used = '0;
    rk = 0;
    for (int c = 0; c < nc; c++) begin
      pr = -1;
      for (int r = 0; r < nr; r++) begin
        if (pr < 0 && !used[r] && a[r*4+c] != 0) begin
          pr = r;
        end
      end
      if (pr >= 0) begin
        used[pr] = 1'b1;
        rk++;
        inv = pow_mod(a[pr*4+c], p - 2, p);
        for (int r = 0; r < nr; r++) begin
          if (!used[r] && a[r*4+c] != 0) begin
            f = (a[r*4+c] * inv) % p;
            for (int k = c; k < nc; k++) begin
              a[r*4+k] = (a[r*4+k] + p - (f * a[pr*4+k]) % p) % p;
            end
          end
        end
      end
    end
    return rk;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic void clear_matrix();
    for (int i = 0; i < MAT_DIM*MAT_DIM; i++) begin
      mat[i] = 0;
    end
  endfunction

  task automatic fill_matrix(input int unsigned p, input int nr, input int nc, input bit nonzero);
    clear_matrix();
    for (int r = 0; r < nr; r++) begin
      for (int c = 0; c < nc; c++) begin
        mat[r*4+c] = nonzero ? 1 + rand_below(p - 1) : rand_below(p);
      end
    end
  endtask

  // Copy, scale or zero one row onto another
  task automatic make_deficient(input int unsigned p, input int nr, input int nc);
    int mode;
    int src;
    int dst;
    longint unsigned s;
    if (nr < 2) begin
      return;
    end
    mode = rand_below(4);
    src = rand_below(nr);
    dst = (src + 1 + rand_below(nr - 1)) % nr;
    s = 1 + rand_below(p - 1);
    for (int c = 0; c < nc; c++) begin
      case (mode)
        1: mat[dst*4+c] = mat[src*4+c];
        2: mat[dst*4+c] = 32'((s * mat[src*4+c]) % p);
        3: mat[dst*4+c] = 0;
        default: ;
      endcase
    end
  endtask

  task automatic check_value(input string what, input int unsigned got, input int unsigned exp);
    assert (got == exp) else begin
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "check failed");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // APB accesses
  ////////////////////////////////////////////////////////////

  task automatic write_word(input paddr_t addr, input logic [31:0] data, output logic err);
    @(posedge CLK);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= addr;
    pwdata <= data;
    @(posedge CLK);
    penable <= 1'b1;
    // Single access cycle with pready high
    @(negedge CLK);
    err = pslverr;
    check_value("pready on write", pready, 1);
    @(posedge CLK);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic read_word(input paddr_t addr, output logic [31:0] data);
    @(posedge CLK);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= addr;
    @(posedge CLK);
    penable <= 1'b1;
    @(negedge CLK);
    data = prdata;
    check_value("pready on read", pready, 1);
    @(posedge CLK);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_checked(input paddr_t addr, input logic [31:0] data, input bit exp_err);
    logic err;
    write_word(addr, data, err);
    check_value("pslverr", err, exp_err);
  endtask

  task automatic wait_for_irq();
    @(negedge CLK);
    while (!irq) begin
      @(negedge CLK);
    end
  endtask

  // Load, start, optionally poke while busy, then check rank, status and irq
  task automatic run_matrix(input int unsigned p, input int nr, input int nc, input bit protect,
                            output int unsigned got);
    logic [31:0] rd;
    int unsigned exp_rank;
    write_checked(REG_MODULO, p, 1'b0);
    write_checked(REG_SIZE, (nc << 4) | nr, 1'b0);
    read_word(REG_MODULO, rd);
    check_value("MODULO readback", rd, p);
    read_word(REG_SIZE, rd);
    check_value("SIZE readback", rd, (nc << 4) | nr);
    for (int r = 0; r < nr; r++) begin
      for (int c = 0; c < nc; c++) begin
        write_checked(paddr_t'(REG_MAT_BASE + 4 * (r * 4 + c)), mat[r*4+c], 1'b0);
      end
    end
    exp_rank = model_rank(p, nr, nc);
    write_checked(REG_CTRL, 32'd1, 1'b0);
    runs++;
    // Busy set, done cleared by the new run
    read_word(REG_STATUS, rd);
    check_value("STATUS after start", rd, 1);
    if (protect) begin
      write_checked(REG_CTRL, 32'd1, 1'b1);
      write_checked(REG_MAT_BASE, (mat[0] + 1) % p, 1'b1);
    end
    wait_for_irq();
    read_word(REG_STATUS, rd);
    check_value("STATUS after irq", rd, 2);
    read_word(REG_RANK, rd);
    check_value("RANK", rd, exp_rank);
    got = rd;
    repeat (4) @(posedge CLK);
    read_word(REG_STATUS, rd);
    check_value("STATUS while idle", rd, 2);
    check_value("irq pulse count", irq_count, runs);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    int unsigned got;
    int unsigned p;
    int nr;
    int nc;
    RST = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    seed = 32'he957;
    primes[0] = 7;
    primes[1] = 251;
    primes[2] = 65521;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;

    // Reset state
    read_word(REG_STATUS, rd);
    check_value("STATUS after reset", rd, 0);
    read_word(REG_MODULO, rd);
    check_value("MODULO after reset", rd, 0);
    check_value("irq pulses after reset", irq_count, 0);

    // All zero
    clear_matrix();
    run_matrix(251, 4, 4, 1'b0, got);
    check_value("zero matrix rank", got, 0);

    // Identities
    clear_matrix();
    for (int i = 0; i < 4; i++) begin
      mat[i*5] = 1;
    end
    run_matrix(7, 4, 4, 1'b0, got);
    check_value("4x4 identity rank", got, 4);
    clear_matrix();
    for (int i = 0; i < 3; i++) begin
      mat[i*5] = 1;
    end
    run_matrix(65521, 3, 3, 1'b0, got);
    check_value("3x3 identity rank", got, 3);

    // Rows 2 and 3 repeat rows 0 and 1
    fill_matrix(251, 4, 3, 1'b0);
    for (int c = 0; c < 3; c++) begin
      mat[8+c] = mat[c];
      mat[12+c] = mat[4+c];
    end
    run_matrix(251, 4, 3, 1'b0, got);

    // Long run with writes refused while busy
    fill_matrix(65521, 4, 4, 1'b1);
    run_matrix(65521, 4, 4, 1'b1, got);

    for (int t = 0; t < 40; t++) begin
      p = primes[rand_below(3)];
      nr = 1 + rand_below(4);
      nc = 1 + rand_below(4);
      fill_matrix(p, nr, nc, 1'b0);
      make_deficient(p, nr, nc);
      run_matrix(p, nr, nc, 1'b0, got);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: ntm_rank_chk.sv
// Bound into every ntm_matrix_rank instance; checks hold only while reset is low.
`default_nettype none

module ntm_rank_chk (
  input wire logic               CLK,
  input wire logic               RST,
  input wire ntm_rank_pkg::cnt_t rows,
  input wire ntm_rank_pkg::cnt_t cols,
  input wire ntm_rank_pkg::cnt_t rank,
  input wire logic               ready,
  input wire logic               busy,
  input wire logic               mul_start,
  input wire logic               add_start
);

  import ntm_rank_pkg::*;

  cnt_t dim_min;
  // Cycles before the multiplier can answer
  int unsigned mul_left;

  assign dim_min = (rows < cols) ? rows : cols;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mul_left <= 0;
    end else if (mul_start) begin
      mul_left <= DATA_W;
    end else if (mul_left != 0) begin
      mul_left <= mul_left - 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Engine invariants
  ////////////////////////////////////////////////////////////

  // Size is frozen while busy, so the bound holds through the ready cycle
  rank_bound: assert property (@(posedge CLK) disable iff (RST)
    (busy || ready) |-> (rank <= dim_min))
    else $error("rank exceeds the smaller matrix dimension");

  // Units never launched together nor while a multiply is still running
  single_unit: assert property (@(posedge CLK) disable iff (RST)
    !(mul_start && add_start) && !((mul_start || add_start) && (mul_left != 0)))
    else $error("scalar unit started together with another or during a multiply");

  busy_after_ready: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !busy)
    else $error("busy still high after ready");

endmodule

bind ntm_matrix_rank ntm_rank_chk ntm_rank_chk_inst (
  .CLK       (CLK),
  .RST       (RST),
  .rows      (rows),
  .cols      (cols),
  .rank      (rank),
  .ready     (ready),
  .busy      (busy),
  .mul_start (mul_start),
  .add_start (add_start)
);

`default_nettype wire

// File: ntm_rank_top.sv
// APB slave with pready tied high. irq pulses once per finished run.
`default_nettype none

module ntm_rank_top (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  input  wire logic                 psel,
  input  wire logic                 penable,
  input  wire logic                 pwrite,
  input  wire ntm_rank_pkg::paddr_t paddr,
  input  wire logic [31:0]          pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      irq
);

  import ntm_rank_pkg::*;

  // Register block to engine
  logic start;
  logic ready;
  logic busy;
  cnt_t rank;
  data_t modulo;
  cnt_t rows;
  cnt_t cols;

  // Buffer ports
  logic apb_wr_en;
  addr_t apb_wr_addr;
  data_t apb_wr_data;
  logic eng_wr_en;
  addr_t eng_wr_addr;
  data_t eng_wr_data;
  addr_t rd_addr_a;
  addr_t rd_addr_b;
  data_t rd_data_a;
  data_t rd_data_b;

  ntm_rank_regs ntm_rank_regs_inst (
    .CLK         (CLK),
    .RST         (RST),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .busy        (busy),
    .ready       (ready),
    .rank        (rank),
    .start       (start),
    .modulo      (modulo),
    .rows        (rows),
    .cols        (cols),
    .apb_wr_en   (apb_wr_en),
    .apb_wr_addr (apb_wr_addr),
    .apb_wr_data (apb_wr_data),
    .irq         (irq)
  );

  ntm_matrix_buffer ntm_matrix_buffer_inst (
    .CLK         (CLK),
    .RST         (RST),
    .apb_wr_en   (apb_wr_en),
    .apb_wr_addr (apb_wr_addr),
    .apb_wr_data (apb_wr_data),
    .eng_wr_en   (eng_wr_en),
    .eng_wr_addr (eng_wr_addr),
    .eng_wr_data (eng_wr_data),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b)
  );

  ntm_matrix_rank ntm_matrix_rank_inst (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .modulo      (modulo),
    .rows        (rows),
    .cols        (cols),
    .ready       (ready),
    .busy        (busy),
    .rank        (rank),
    .rd_addr_a   (rd_addr_a),
    .rd_data_a   (rd_data_a),
    .rd_addr_b   (rd_addr_b),
    .rd_data_b   (rd_data_b),
    .eng_wr_en   (eng_wr_en),
    .eng_wr_addr (eng_wr_addr),
    .eng_wr_data (eng_wr_data)
  );

endmodule

`default_nettype wire

// File: ntm_matrix_rank.sv
// Needs a prime modulus and reduced elements. The matrix in the buffer is overwritten by the run.
`default_nettype none

module ntm_matrix_rank (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  wire logic                start,
  input  wire ntm_rank_pkg::data_t modulo,
  input  wire ntm_rank_pkg::cnt_t  rows,
  input  wire ntm_rank_pkg::cnt_t  cols,
  output logic                     ready,
  output logic                     busy,
  output ntm_rank_pkg::cnt_t       rank,
  // Buffer access
  output ntm_rank_pkg::addr_t      rd_addr_a,
  input  wire ntm_rank_pkg::data_t rd_data_a,
  output ntm_rank_pkg::addr_t      rd_addr_b,
  input  wire ntm_rank_pkg::data_t rd_data_b,
  output logic                     eng_wr_en,
  output ntm_rank_pkg::addr_t      eng_wr_addr,
  output ntm_rank_pkg::data_t      eng_wr_data
);

  import ntm_rank_pkg::*;

  rank_state_t state;
  // Current column, and scan row
  cnt_t col;
  cnt_t row;
  // Element column during a row update
  idx_t k;
  idx_t pivot_row;
  logic have_pivot;
  // Rows already used as pivots
  logic [MAT_DIM-1:0] used;
  data_t pivot;
  data_t lead;
  // pivot * element, kept across the second multiply
  data_t prod_a;

  logic search_ok;
  logic cand;
  logic take_pivot;
  logic take_lead;
  logic last_elem;

  logic mul_start;
  logic mul_ready;
  data_t mul_a;
  data_t mul_b;
  data_t mul_out;
  logic add_start;
  logic add_ready;
  data_t add_out;

  ////////////////////////////////////////////////////////////
  // Buffer addressing
  ////////////////////////////////////////////////////////////

  // Port A is the scanned or updated row, port B the pivot row
  assign rd_addr_a = {row[IDX_W-1:0], (state == SEARCH) ? col[IDX_W-1:0] : k};
  assign rd_addr_b = {pivot_row, k};

  // Write back in place of the element just read
  assign eng_wr_en = (state == WRITE);
  assign eng_wr_addr = rd_addr_a;
  assign eng_wr_data = add_out;

  // Unused row with a nonzero entry in this column
  assign search_ok = (state == SEARCH) && (col != cols) && (row != rows);
  assign cand = !used[row[IDX_W-1:0]] && (rd_data_a != '0);
  assign take_pivot = search_ok && cand && !have_pivot;
  assign take_lead = search_ok && cand && have_pivot;
  assign last_elem = (cnt_t'(k) + cnt_t'(1) == cols);

  ////////////////////////////////////////////////////////////
  // Scalar unit sequencing
  ////////////////////////////////////////////////////////////

  // First pivot*element, then lead*pivot-row element
  assign mul_start = (state == LOAD) || ((state == MUL_A) && mul_ready);
  assign mul_a = (state == LOAD) ? pivot : lead;
  assign mul_b = (state == LOAD) ? rd_data_a : rd_data_b;
  // Subtract once the second product is in
  assign add_start = (state == MUL_B) && mul_ready;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      col <= '0;
      row <= '0;
      k <= '0;
      pivot_row <= '0;
      have_pivot <= 1'b0;
      used <= '0;
      rank <= '0;
      ready <= 1'b0;
      busy <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            col <= '0;
            row <= '0;
            have_pivot <= 1'b0;
            used <= '0;
            rank <= '0;
            busy <= 1'b1;
            state <= SEARCH;
          end
        end
        SEARCH: begin
          if (col == cols) begin
            state <= FINISH;
          end else if (row == rows) begin
            state <= NEXT;
          end else if (take_pivot) begin
            // First hit in this column becomes the pivot
            pivot_row <= row[IDX_W-1:0];
            used[row[IDX_W-1:0]] <= 1'b1;
            rank <= rank + 1'b1;
            have_pivot <= 1'b1;
            row <= row + 1'b1;
          end else if (take_lead) begin
            // Rewrite this row from the current column on
            k <= col[IDX_W-1:0];
            state <= LOAD;
          end else begin
            row <= row + 1'b1;
          end
        end
        LOAD: state <= MUL_A;
        MUL_A: begin
          if (mul_ready) begin
            state <= MUL_B;
          end
        end
        MUL_B: begin
          if (mul_ready) begin
            state <= SUB;
          end
        end
        SUB: begin
          if (add_ready) begin
            state <= WRITE;
          end
        end
        WRITE: begin
          if (last_elem) begin
            row <= row + 1'b1;
            state <= SEARCH;
          end else begin
            k <= k + 1'b1;
            state <= LOAD;
          end
        end
        NEXT: begin
          col <= col + 1'b1;
          row <= '0;
          have_pivot <= 1'b0;
          state <= SEARCH;
        end
        FINISH: begin
          // Busy drops with the ready pulse
          ready <= 1'b1;
          busy <= 1'b0;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operand holding registers
  always_ff @(posedge CLK) begin
    if (take_pivot) begin
      pivot <= rd_data_a;
    end
    if (take_lead) begin
      lead <= rd_data_a;
    end
    if ((state == MUL_A) && mul_ready) begin
      prod_a <= mul_out;
    end
  end

  ntm_scalar_multiplier ntm_scalar_multiplier_inst (
    .CLK      (CLK),
    .RST      (RST),
    .start    (mul_start),
    .modulo   (modulo),
    .data_a   (mul_a),
    .data_b   (mul_b),
    .ready    (mul_ready),
    .data_out (mul_out)
  );

  ntm_scalar_adder ntm_scalar_adder_inst (
    .CLK       (CLK),
    .RST       (RST),
    .start     (add_start),
    .operation (1'b1),
    .modulo    (modulo),
    .data_a    (prod_a),
    .data_b    (mul_out),
    .ready     (add_ready),
    .data_out  (add_out)
  );

endmodule

`default_nettype wire

// File: ntm_scalar_multiplier.sv
// Operands must be reduced below a nonzero modulus. Ready comes DATA_W+1 cycles after start.
`default_nettype none

module ntm_scalar_multiplier (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  wire logic                start,
  input  wire ntm_rank_pkg::data_t modulo,
  input  wire ntm_rank_pkg::data_t data_a,
  input  wire ntm_rank_pkg::data_t data_b,
  output logic                     ready,
  output ntm_rank_pkg::data_t      data_out
);

  import ntm_rank_pkg::*;

  logic active;
  logic [$clog2(DATA_W+1)-1:0] step;
  data_t a_q;
  // Multiplier bits, scanned MSB first
  data_t b_q;
  data_t acc;
  logic [DATA_W:0] dbl;
  logic [DATA_W:0] dbl_red;
  logic [DATA_W:0] add;
  logic [DATA_W:0] add_red;

  ////////////////////////////////////////////////////////////
  // One Horner step
  ////////////////////////////////////////////////////////////

  // acc*2 mod m
  assign dbl = {acc, 1'b0};
  assign dbl_red = (dbl >= {1'b0, modulo}) ? dbl - {1'b0, modulo} : dbl;
  // Plus a when the current bit is set
  assign add = b_q[DATA_W-1] ? dbl_red + {1'b0, a_q} : dbl_red;
  assign add_red = (add >= {1'b0, modulo}) ? add - {1'b0, modulo} : add;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active <= 1'b0;
      step <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        active <= 1'b1;
        step <= '0;
      end else if (active) begin
        step <= step + 1'b1;
        // Last bit done, result in acc
        if (step == DATA_W - 1) begin
          active <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (start) begin
      a_q <= data_a;
      b_q <= data_b;
      acc <= '0;
    end else if (active) begin
      acc <= add_red[DATA_W-1:0];
      b_q <= {b_q[DATA_W-2:0], 1'b0};
    end
  end

  assign data_out = acc;

endmodule

`default_nettype wire

// File: ntm_scalar_adder.sv
// Operands must already be below the modulus. One correction step brings the result back in range.
`default_nettype none

module ntm_scalar_adder (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  wire logic                start,
  // 0 add, 1 subtract
  input  wire logic                operation,
  input  wire ntm_rank_pkg::data_t modulo,
  input  wire ntm_rank_pkg::data_t data_a,
  input  wire ntm_rank_pkg::data_t data_b,
  output logic                     ready,
  output ntm_rank_pkg::data_t      data_out
);

  import ntm_rank_pkg::*;

  // One extra bit for the carry
  logic [DATA_W:0] sum;
  data_t diff;
  data_t result;

  // a+b can reach 2m-2
  assign sum = {1'b0, data_a} + {1'b0, data_b};
  assign diff = data_a - data_b;

  always_comb begin
    if (operation) begin
      // Borrow means wrap by adding m
      result = (data_a < data_b) ? diff + modulo : diff;
    end else begin
      result = (sum >= {1'b0, modulo}) ? data_t'(sum - {1'b0, modulo}) : sum[DATA_W-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready <= 1'b0;
    end else begin
      ready <= start;
    end
  end

  // Held until the next start
  always_ff @(posedge CLK) begin
    if (start) begin
      data_out <= result;
    end
  end

endmodule

`default_nettype wire

// File: ntm_matrix_buffer.sv
// Write ports are never active together by contract. The engine port wins if both are set.
`default_nettype none

module ntm_matrix_buffer (
  input  wire logic                CLK,
  input  wire logic                RST,
  // APB element write
  input  wire logic                apb_wr_en,
  input  wire ntm_rank_pkg::addr_t apb_wr_addr,
  input  wire ntm_rank_pkg::data_t apb_wr_data,
  // Engine write back
  input  wire logic                eng_wr_en,
  input  wire ntm_rank_pkg::addr_t eng_wr_addr,
  input  wire ntm_rank_pkg::data_t eng_wr_data,
  // Two combinational reads
  input  wire ntm_rank_pkg::addr_t rd_addr_a,
  input  wire ntm_rank_pkg::addr_t rd_addr_b,
  output ntm_rank_pkg::data_t      rd_data_a,
  output ntm_rank_pkg::data_t      rd_data_b
);

  import ntm_rank_pkg::*;

  // Row major, row*4 + column
  data_t mem [MAT_DIM*MAT_DIM];

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < MAT_DIM*MAT_DIM; i++) begin
        mem[i] <= '0;
      end
    end else if (eng_wr_en) begin
      mem[eng_wr_addr] <= eng_wr_data;
    end else if (apb_wr_en) begin
      mem[apb_wr_addr] <= apb_wr_data;
    end
  end

  // Row j element and pivot row element fetched together
  assign rd_data_a = mem[rd_addr_a];
  assign rd_data_b = mem[rd_addr_b];

endmodule

`default_nettype wire

// File: ntm_rank_regs.sv
// No wait states. Writes to CTRL or the matrix while busy get pslverr, and element readback is zero.
`default_nettype none

module ntm_rank_regs (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  // APB slave
  input  wire logic                 psel,
  input  wire logic                 penable,
  input  wire logic                 pwrite,
  input  wire ntm_rank_pkg::paddr_t paddr,
  input  wire logic [31:0]          pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  // Engine side
  input  wire logic                 busy,
  input  wire logic                 ready,
  input  wire ntm_rank_pkg::cnt_t   rank,
  output logic                      start,
  output ntm_rank_pkg::data_t       modulo,
  output ntm_rank_pkg::cnt_t        rows,
  output ntm_rank_pkg::cnt_t        cols,
  // Element write into the buffer
  output logic                      apb_wr_en,
  output ntm_rank_pkg::addr_t       apb_wr_addr,
  output ntm_rank_pkg::data_t       apb_wr_data,
  output logic                      irq
);

  import ntm_rank_pkg::*;

  logic wr_acc;
  logic is_mat;
  logic protect_hit;
  logic done;
  cnt_t rank_q;

  ////////////////////////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////////////////////////

  // Access phase of a write
  assign wr_acc = psel && penable && pwrite;
  // Matrix window 0x40..0x7C
  assign is_mat = (paddr[7:6] == REG_MAT_BASE[7:6]);
  // Targets a running computation depends on
  assign protect_hit = (paddr == REG_CTRL) || is_mat;

  assign pready = 1'b1;
  assign pslverr = wr_acc && busy && protect_hit;

  // Element writes go straight through in the access cycle
  assign apb_wr_en = wr_acc && is_mat && !busy;
  assign apb_wr_addr = paddr[5:2];
  assign apb_wr_data = pwdata[DATA_W-1:0];

  ////////////////////////////////////////////////////////////
  // Configuration and control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      modulo <= '0;
      rows <= '0;
      cols <= '0;
      start <= 1'b0;
      done <= 1'b0;
      rank_q <= '0;
      irq <= 1'b0;
    end else begin
      // Start pulse one cycle after the accepted CTRL write
      start <= wr_acc && !busy && (paddr == REG_CTRL) && pwdata[0];
      // Config frozen while a run is in flight
      if (wr_acc && !busy && (paddr == REG_MODULO)) begin
        modulo <= pwdata[DATA_W-1:0];
      end
      if (wr_acc && !busy && (paddr == REG_SIZE)) begin
        rows <= pwdata[2:0];
        cols <= pwdata[6:4];
      end
      // Sticky done, cleared by the next run
      if (start) begin
        done <= 1'b0;
      end else if (ready) begin
        done <= 1'b1;
      end
      if (ready) begin
        rank_q <= rank;
      end
      // One irq pulse per finished run
      irq <= ready;
    end
  end

  ////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        REG_STATUS: prdata = {30'd0, done, busy};
        REG_MODULO: prdata = {{(32-DATA_W){1'b0}}, modulo};
        REG_SIZE:   prdata = {25'd0, cols, 1'b0, rows};
        REG_RANK:   prdata = {{(32-CNT_W){1'b0}}, rank_q};
        // CTRL, matrix and holes read zero
        default:    prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: ntm_rank_pkg.sv
// Matrix is at most 4 by 4 with 16-bit residues. Registers sit on 32-bit word offsets.
`default_nettype none

package ntm_rank_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Residue and modulus width
  localparam int DATA_W = 16;
  // Largest row or column count
  localparam int MAT_DIM = 4;
  localparam int IDX_W = 2;
  // Counts 0 to 4 for size and rank
  localparam int CNT_W = 3;
  // Buffer address is row times 4 plus column
  localparam int ADDR_W = 4;
  localparam int APB_ADDR_W = 8;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [APB_ADDR_W-1:0] paddr_t;

  // Rank engine states
  typedef enum logic [3:0] {
    IDLE,
    SEARCH,
    LOAD,
    MUL_A,
    MUL_B,
    SUB,
    WRITE,
    NEXT,
    FINISH
  } rank_state_t;

  ////////////////////////////////////////////////////////////
  // APB register map
  ////////////////////////////////////////////////////////////

  // Bit 0 starts a run
  localparam paddr_t REG_CTRL = 8'h00;
  // Bit 0 busy, bit 1 done
  localparam paddr_t REG_STATUS = 8'h04;
  localparam paddr_t REG_MODULO = 8'h08;
  // Rows in 2..0, columns in 6..4
  localparam paddr_t REG_SIZE = 8'h0C;
  localparam paddr_t REG_RANK = 8'h10;
  // Element r,c at base plus 4*(4r+c)
  localparam paddr_t REG_MAT_BASE = 8'h40;

endpackage

`default_nettype wire
